// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module tb_datapath -Mdir obj_dir -o Vtb_datapath

run: compile
	./obj_dir/Vtb_datapath > sim.log 2>&1; cat sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== alu.sv ====
`timescale 1ns/10ps

module alu (
  input  cpuPkg::aluOp_t                 op,
  input  logic [cpuPkg::dataWidth-1:0]   a,
  input  logic [cpuPkg::dataWidth-1:0]   b,
  output logic [2*cpuPkg::dataWidth-1:0] result
);

  logic [4:0]                       shiftAmount;
  logic [2*cpuPkg::dataWidth-1:0]   rorWide;
  logic [2*cpuPkg::dataWidth-1:0]   rolWide;
  logic signed [2*cpuPkg::dataWidth-1:0] aWide;
  logic signed [2*cpuPkg::dataWidth-1:0] bWide;
  logic signed [2*cpuPkg::dataWidth-1:0] product;
  logic signed [cpuPkg::dataWidth-1:0]   aSigned;
  logic signed [cpuPkg::dataWidth-1:0]   bSigned;
  logic [cpuPkg::dataWidth-1:0]     quotient;
  logic [cpuPkg::dataWidth-1:0]     remainder;

  assign shiftAmount = b[4:0];

  // rotate by shifting a doubled copy of a.
  assign rorWide = {a, a} >> shiftAmount;
  assign rolWide = {a, a} << shiftAmount;

  assign aWide   = {{cpuPkg::dataWidth{a[cpuPkg::dataWidth-1]}}, a};
  assign bWide   = {{cpuPkg::dataWidth{b[cpuPkg::dataWidth-1]}}, b};
  assign product = aWide * bWide;

  assign aSigned = a;
  assign bSigned = b;

  // divide by zero returns all ones and leaves the dividend as remainder.
  always_comb begin
    if (b == '0) begin
      quotient  = '1;
      remainder = a;
    end else begin
      quotient  = aSigned / bSigned;
      remainder = aSigned % bSigned;
    end
  end

  always_comb begin
    result = '0;
    case (op)
      cpuPkg::opAdd:   result[cpuPkg::dataWidth-1:0] = a + b;
      cpuPkg::opSub:   result[cpuPkg::dataWidth-1:0] = a - b;
      cpuPkg::opAnd:   result[cpuPkg::dataWidth-1:0] = a & b;
      cpuPkg::opOr:    result[cpuPkg::dataWidth-1:0] = a | b;
      cpuPkg::opShr:   result[cpuPkg::dataWidth-1:0] = a >> shiftAmount;
      cpuPkg::opShl:   result[cpuPkg::dataWidth-1:0] = a << shiftAmount;
      cpuPkg::opRor:   result[cpuPkg::dataWidth-1:0] = rorWide[cpuPkg::dataWidth-1:0];
      cpuPkg::opRol: begin
        result[cpuPkg::dataWidth-1:0] = rolWide[2*cpuPkg::dataWidth-1:cpuPkg::dataWidth];
      end
      cpuPkg::opMul:   result = product;
      cpuPkg::opDiv:   result = {remainder, quotient};
      // neg and not act on the bus operand only.
      cpuPkg::opNeg:   result[cpuPkg::dataWidth-1:0] = -b;
      cpuPkg::opNot:   result[cpuPkg::dataWidth-1:0] = ~b;
      cpuPkg::opPassB: result[cpuPkg::dataWidth-1:0] = b;
      default:         result = '0;
    endcase
  end

endmodule

// ==== busMux.sv ====
`timescale 1ns/10ps

module busMux (
  input  cpuPkg::controlWord_t          ctrl,
  input  logic [cpuPkg::dataWidth-1:0]  regData,
  input  logic [cpuPkg::dataWidth-1:0]  hiData,
  input  logic [cpuPkg::dataWidth-1:0]  loData,
  input  logic [2*cpuPkg::dataWidth-1:0] zData,
  input  logic [cpuPkg::dataWidth-1:0]  pcData,
  input  logic [cpuPkg::dataWidth-1:0]  mdrData,
  output logic [cpuPkg::dataWidth-1:0]  busValue,
  output cpuPkg::busSource_t            source
);

  logic [cpuPkg::numRegs+5:0] outStrobes;

  assign outStrobes = {ctrl.regOut, ctrl.hiOut, ctrl.loOut, ctrl.zHighOut,
                       ctrl.zLowOut, ctrl.pcOut, ctrl.mdrOut};

  // fixed priority encoder, general registers first, MDR last.
  always_comb begin
    source = cpuPkg::srcNone;
    if (ctrl.regOut != '0) begin
      for (int i = cpuPkg::numRegs - 1; i >= 0; i--) begin
        if (ctrl.regOut[i]) begin
          source = cpuPkg::busSource_t'(int'(cpuPkg::srcR0) + i);
        end
      end
    end else if (ctrl.hiOut) begin
      source = cpuPkg::srcHi;
    end else if (ctrl.loOut) begin
      source = cpuPkg::srcLo;
    end else if (ctrl.zHighOut) begin
      source = cpuPkg::srcZHigh;
    end else if (ctrl.zLowOut) begin
      source = cpuPkg::srcZLow;
    end else if (ctrl.pcOut) begin
      source = cpuPkg::srcPc;
    end else if (ctrl.mdrOut) begin
      source = cpuPkg::srcMdr;
    end
  end

  // the register file already resolved which general register is selected.
  always_comb begin
    case (source)
      cpuPkg::srcNone:  busValue = '0;
      cpuPkg::srcHi:    busValue = hiData;
      cpuPkg::srcLo:    busValue = loData;
      cpuPkg::srcZHigh: busValue = zData[2*cpuPkg::dataWidth-1:cpuPkg::dataWidth];
      cpuPkg::srcZLow:  busValue = zData[cpuPkg::dataWidth-1:0];
      cpuPkg::srcPc:    busValue = pcData;
      cpuPkg::srcMdr:   busValue = mdrData;
      default:          busValue = regData;
    endcase
  end

  // the control side must never drive two peers at once.
  always_comb begin
    if (!$isunknown(outStrobes)) begin
      assert ($onehot0(outStrobes))
        else $error("busMux: more than one out strobe high");
    end
  end

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

  // word width of the shared bus and of every 32-bit register.
  localparam int dataWidth = 32;

  // number of general purpose registers.
  localparam int numRegs = 16;

  // ALU operations, selected once per cycle by the control word.
  typedef enum logic [3:0] {
    opAdd,
    opSub,
    opAnd,
    opOr,
    opShr,
    opShl,
    opRor,
    opRol,
    opMul,
    opDiv,
    opNeg,
    opNot,
    opPassB
  } aluOp_t;

  // bus sources in priority order, lowest value wins.
  typedef enum logic [4:0] {
    srcNone,
    srcR0,  srcR1,  srcR2,  srcR3,
    srcR4,  srcR5,  srcR6,  srcR7,
    srcR8,  srcR9,  srcR10, srcR11,
    srcR12, srcR13, srcR14, srcR15,
    srcHi,
    srcLo,
    srcZHigh,
    srcZLow,
    srcPc,
    srcMdr
  } busSource_t;

  // one cycle worth of level strobes for the datapath.
  typedef struct packed {
    logic [numRegs-1:0] regIn;
    logic [numRegs-1:0] regOut;
    logic               pcIn;
    logic               pcOut;
    logic               incPc;
    logic               irIn;
    logic               yIn;
    logic               zIn;
    logic               zHighOut;
    logic               zLowOut;
    logic               hiIn;
    logic               hiOut;
    logic               loIn;
    logic               loOut;
    logic               marIn;
    logic               mdrIn;
    logic               mdrOut;
    logic               memRead;
    aluOp_t             aluOp;
  } controlWord_t;

endpackage

// ==== datapath.sv ====
`timescale 1ns/10ps

module datapath (
  input  logic                          clock,
  input  logic                          reset,
  input  cpuPkg::controlWord_t          ctrl,
  input  logic [cpuPkg::dataWidth-1:0]  mDataIn,
  output logic [cpuPkg::dataWidth-1:0]  busValue,
  output logic [cpuPkg::dataWidth-1:0]  mar,
  output logic [cpuPkg::dataWidth-1:0]  ir
);

  logic [cpuPkg::dataWidth-1:0]   regData;
  logic [cpuPkg::dataWidth-1:0]   pcData;
  logic [cpuPkg::dataWidth-1:0]   hiData;
  logic [cpuPkg::dataWidth-1:0]   loData;
  logic [cpuPkg::dataWidth-1:0]   yData;
  logic [cpuPkg::dataWidth-1:0]   mdrData;
  logic [2*cpuPkg::dataWidth-1:0] zData;
  logic [2*cpuPkg::dataWidth-1:0] aluResult;

  registerFile u_registerFile (
    .clock    (clock),
    .reset    (reset),
    .regIn    (ctrl.regIn),
    .regOut   (ctrl.regOut),
    .busValue (busValue),
    .regData  (regData)
  );

  // encoded source is left open here, it is for waveform debug.
  busMux u_busMux (
    .ctrl     (ctrl),
    .regData  (regData),
    .hiData   (hiData),
    .loData   (loData),
    .zData    (zData),
    .pcData   (pcData),
    .mdrData  (mdrData),
    .busValue (busValue),
    .source   ()
  );

  alu u_alu (
    .op     (ctrl.aluOp),
    .a      (yData),
    .b      (busValue),
    .result (aluResult)
  );

  mdr u_mdr (
    .clock    (clock),
    .reset    (reset),
    .mdrIn    (ctrl.mdrIn),
    .memRead  (ctrl.memRead),
    .busValue (busValue),
    .mDataIn  (mDataIn),
    .mdrData  (mdrData)
  );

  specialRegs u_specialRegs (
    .clock     (clock),
    .reset     (reset),
    .ctrl      (ctrl),
    .busValue  (busValue),
    .aluResult (aluResult),
    .pcData    (pcData),
    .hiData    (hiData),
    .loData    (loData),
    .irData    (ir),
    .yData     (yData),
    .marData   (mar),
    .zData     (zData)
  );

endmodule

// ==== mdr.sv ====
`timescale 1ns/10ps

module mdr (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          mdrIn,
  input  logic                          memRead,
  input  logic [cpuPkg::dataWidth-1:0]  busValue,
  input  logic [cpuPkg::dataWidth-1:0]  mDataIn,
  output logic [cpuPkg::dataWidth-1:0]  mdrData
);

  logic [cpuPkg::dataWidth-1:0] loadValue;

  // read select picks memory over the bus.
  assign loadValue = memRead ? mDataIn : busValue;

  always_ff @(posedge clock) begin
    if (reset) begin
      mdrData <= '0;
    end else if (mdrIn) begin
      mdrData <= loadValue;
    end
  end

endmodule

// ==== registerFile.sv ====
`timescale 1ns/10ps

module registerFile (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [cpuPkg::numRegs-1:0]    regIn,
  input  logic [cpuPkg::numRegs-1:0]    regOut,
  input  logic [cpuPkg::dataWidth-1:0]  busValue,
  output logic [cpuPkg::dataWidth-1:0]  regData
);

  logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::numRegs];

  // every register with its in strobe set takes the bus value.
  always_ff @(posedge clock) begin
    for (int i = 0; i < cpuPkg::numRegs; i++) begin
      if (reset) begin
        regs[i] <= '0;
      end else if (regIn[i]) begin
        regs[i] <= busValue;
      end
    end
  end

  // walk from the top down so the lowest set out strobe is the one kept.
  always_comb begin
    regData = '0;
    for (int i = cpuPkg::numRegs - 1; i >= 0; i--) begin
      if (regOut[i]) begin
        regData = regs[i];
      end
    end
  end

  // two registers on the bus in the same cycle would corrupt whatever loads from it.
  regOutOneHot: assert property (
    @(posedge clock) disable iff (reset) $onehot0(regOut)
  ) else $error("registerFile: more than one regOut bit set");

endmodule

// ==== sim.f ====
cpuPkg.sv
registerFile.sv
busMux.sv
alu.sv
mdr.sv
specialRegs.sv
datapath.sv
tb_datapath.sv

// ==== specialRegs.sv ====
`timescale 1ns/10ps

module specialRegs (
  input  logic                           clock,
  input  logic                           reset,
  input  cpuPkg::controlWord_t           ctrl,
  input  logic [cpuPkg::dataWidth-1:0]   busValue,
  input  logic [2*cpuPkg::dataWidth-1:0] aluResult,
  output logic [cpuPkg::dataWidth-1:0]   pcData,
  output logic [cpuPkg::dataWidth-1:0]   hiData,
  output logic [cpuPkg::dataWidth-1:0]   loData,
  output logic [cpuPkg::dataWidth-1:0]   irData,
  output logic [cpuPkg::dataWidth-1:0]   yData,
  output logic [cpuPkg::dataWidth-1:0]   marData,
  output logic [2*cpuPkg::dataWidth-1:0] zData
);

  // PC increment wins over a bus load.
  always_ff @(posedge clock) begin
    if (reset) begin
      pcData <= '0;
    end else if (ctrl.incPc) begin
      pcData <= pcData + 1'b1;
    end else if (ctrl.pcIn) begin
      pcData <= busValue;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      irData  <= '0;
      yData   <= '0;
      hiData  <= '0;
      loData  <= '0;
      marData <= '0;
      zData   <= '0;
    end else begin
      if (ctrl.irIn)  irData  <= busValue;
      if (ctrl.yIn)   yData   <= busValue;
      if (ctrl.hiIn)  hiData  <= busValue;
      if (ctrl.loIn)  loData  <= busValue;
      if (ctrl.marIn) marData <= busValue;
      // Z takes both halves of the ALU result together.
      if (ctrl.zIn)   zData   <= aluResult;
    end
  end

  pcLoadExclusive: assert property (
    @(posedge clock) disable iff (reset) !(ctrl.incPc && ctrl.pcIn)
  ) else $error("specialRegs: incPc and pcIn high together");

endmodule

// ==== tb_datapath.sv ====
`timescale 1ns/10ps

module tb_datapath;

  localparam int peerReads = 22;
  localparam int memOps    = 16;
  localparam int moveOps   = 24;
  localparam int aluOps    = 30;
  localparam int pcOps     = 8;
  // one op is up to 4 cycles, a move or PC run is counted as several ops.
  localparam int numOps  = 1 + peerReads + memOps + 2 * moveOps + aluOps + 3 * pcOps;
  localparam int limitNs = numOps * 4 * 4 + 200;

  logic                         clock;
  logic                         reset;
  cpuPkg::controlWord_t         ctrl;
  logic [cpuPkg::dataWidth-1:0] mDataIn;
  logic [cpuPkg::dataWidth-1:0] busValue;
  logic [cpuPkg::dataWidth-1:0] mar;
  logic [cpuPkg::dataWidth-1:0] ir;

  logic [31:0] seed;
  logic [31:0] lastBus;
  logic [31:0] regM [16];
  logic [31:0] pcM, yM, hiM, loM, marM, mdrM, irM;
  logic [63:0] zM;

  datapath u_dut (
    .clock    (clock),
    .reset    (reset),
    .ctrl     (ctrl),
    .mDataIn  (mDataIn),
    .busValue (busValue),
    .mar      (mar),
    .ir       (ir)
  );

  always #2 clock = ~clock;

  function logic [31:0] nextRand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "value mismatch, run stopped");
    end
  endtask

  // reference ALU, written from the opcode rules.
  function automatic logic [63:0] aluModel(cpuPkg::aluOp_t op, logic [31:0] a,
                                           logic [31:0] b);
    longint      sa;
    longint      sb;
    logic [31:0] q;
    logic [31:0] r;
    logic [4:0]  s;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    s  = b[4:0];
    case (op)
      cpuPkg::opAdd:   return {32'd0, a + b};
      cpuPkg::opSub:   return {32'd0, a - b};
      cpuPkg::opAnd:   return {32'd0, a & b};
      cpuPkg::opOr:    return {32'd0, a | b};
      cpuPkg::opShr:   return {32'd0, a >> s};
      cpuPkg::opShl:   return {32'd0, a << s};
      cpuPkg::opRor:   return {32'd0, (a >> s) | (a << (32 - s))};
      cpuPkg::opRol:   return {32'd0, (a << s) | (a >> (32 - s))};
      cpuPkg::opMul:   return sa * sb;
      cpuPkg::opDiv: begin
        if (b == 32'd0) begin
          return {a, 32'hffffffff};
        end
        q = sa / sb;
        r = sa % sb;
        return {r, q};
      end
      cpuPkg::opNeg:   return {32'd0, -b};
      cpuPkg::opNot:   return {32'd0, ~b};
      cpuPkg::opPassB: return {32'd0, b};
      default:         return 64'd0;
    endcase
  endfunction

  // expected bus value, by the fixed source priority.
  function automatic logic [31:0] modelBus(cpuPkg::controlWord_t c);
    for (int i = 0; i < 16; i++) begin
      if (c.regOut[i]) return regM[i];
    end
    if (c.hiOut) return hiM;
    if (c.loOut) return loM;
    if (c.zHighOut) return zM[63:32];
    if (c.zLowOut) return zM[31:0];
    if (c.pcOut) return pcM;
    if (c.mdrOut) return mdrM;
    return 32'd0;
  endfunction

  // drive one control word, check the bus, then advance the model past the edge.
  task automatic runCycle(input string name, input cpuPkg::controlWord_t c);
    logic [31:0] expBus;
    logic [63:0] expAlu;
    ctrl = c;
    #1;
    expBus  = modelBus(c);
    lastBus = busValue;
    check({name, " bus"}, {32'd0, expBus}, {32'd0, busValue});
    expAlu = aluModel(c.aluOp, yM, expBus);
    for (int i = 0; i < 16; i++) begin
      if (c.regIn[i]) regM[i] = expBus;
    end
    if (c.incPc) pcM = pcM + 32'd1;
    else if (c.pcIn) pcM = expBus;
    if (c.irIn) irM = expBus;
    if (c.yIn) yM = expBus;
    if (c.hiIn) hiM = expBus;
    if (c.loIn) loM = expBus;
    if (c.marIn) marM = expBus;
    if (c.zIn) zM = expAlu;
    if (c.mdrIn) mdrM = c.memRead ? mDataIn : expBus;
    @(posedge clock);
    #1;
    check({name, " ir"}, irM, ir);
    check({name, " mar"}, marM, mar);
  endtask

  initial begin
    cpuPkg::controlWord_t c;
    int          src;
    int          dst;
    int          count;
    logic [31:0] data;
    logic [31:0] expPc;
    cpuPkg::aluOp_t op;
    clock   = 1'b0;
    reset   = 1'b1;
    ctrl    = '0;
    mDataIn = '0;
    seed    = 32'h8ba28709;
    lastBus = '0;
    pcM = '0;
    yM = '0;
    hiM = '0;
    loM = '0;
    marM = '0;
    mdrM = '0;
    irM = '0;
    zM = '0;
    for (int i = 0; i < 16; i++) regM[i] = '0;
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;

    // nothing drives the bus after reset.
    check("reset bus", 64'd0, busValue);
    c = '0;
    runCycle("reset idle", c);
    check("reset mar", 64'd0, mar);
    check("reset ir", 64'd0, ir);

    // every peer reads back zero straight after reset.
    for (int i = 0; i < peerReads; i++) begin
      c = '0;
      case (i)
        16:      c.hiOut    = 1'b1;
        17:      c.loOut    = 1'b1;
        18:      c.zHighOut = 1'b1;
        19:      c.zLowOut  = 1'b1;
        20:      c.pcOut    = 1'b1;
        21:      c.mdrOut   = 1'b1;
        default: c.regOut[i] = 1'b1;
      endcase
      runCycle("reset readback", c);
    end

    // memory word through MDR into every general register.
    for (int r = 0; r < memOps; r++) begin
      data    = nextRand();
      mDataIn = data;
      c = '0;
      c.mdrIn   = 1'b1;
      c.memRead = 1'b1;
      runCycle("mem to mdr", c);
      c = '0;
      c.mdrOut    = 1'b1;
      c.regIn[r]  = 1'b1;
      runCycle("mdr to reg", c);
      c = '0;
      c.regOut[r] = 1'b1;
      runCycle("reg readback", c);
      check("mem load path", data, lastBus);
    end

    for (int k = 0; k < moveOps; k++) begin
      src = nextRand() >> 28;
      dst = nextRand() >> 28;
      c = '0;
      c.regOut[src] = 1'b1;
      c.regIn[dst]  = 1'b1;
      runCycle("reg move", c);
      c = '0;
      c.regOut[dst] = 1'b1;
      c.hiIn = 1'b1;
      c.irIn = 1'b1;
      runCycle("move to hi ir", c);
      c = '0;
      c.regOut[src] = 1'b1;
      c.loIn  = 1'b1;
      c.marIn = 1'b1;
      runCycle("move to lo mar", c);
      c = '0;
      c.hiOut = 1'b1;
      runCycle("hi readback", c);
      c = '0;
      c.loOut = 1'b1;
      runCycle("lo readback", c);
    end

    // R15 gets zero from the idle bus, for the divide by zero case.
    c = '0;
    c.regIn[15] = 1'b1;
    runCycle("clear r15", c);
    for (int k = 0; k < aluOps; k++) begin
      if (k < 13) begin
        op = cpuPkg::aluOp_t'(k);
      end else if (k == aluOps - 1) begin
        op = cpuPkg::opDiv;
      end else begin
        op = cpuPkg::aluOp_t'((nextRand() >> 16) % 13);
      end
      src = nextRand() >> 28;
      // only the last pass takes R15, so the sweep divides by a nonzero word.
      dst = (k == aluOps - 1) ? 15 : int'((nextRand() >> 16) % 15);
      c = '0;
      c.regOut[src] = 1'b1;
      c.yIn = 1'b1;
      runCycle("load y", c);
      c = '0;
      c.regOut[dst] = 1'b1;
      c.zIn   = 1'b1;
      c.aluOp = op;
      runCycle("alu op", c);
      c = '0;
      c.zLowOut = 1'b1;
      runCycle({"z low ", op.name()}, c);
      c = '0;
      c.zHighOut = 1'b1;
      runCycle({"z high ", op.name()}, c);
    end

    for (int k = 0; k < pcOps; k++) begin
      data    = nextRand();
      mDataIn = data;
      c = '0;
      c.mdrIn   = 1'b1;
      c.memRead = 1'b1;
      runCycle("pc start to mdr", c);
      c = '0;
      c.mdrOut = 1'b1;
      c.pcIn   = 1'b1;
      runCycle("pc load", c);
      count = (nextRand() >> 29) + 1;
      c = '0;
      c.incPc = 1'b1;
      repeat (count) runCycle("pc inc", c);
      c = '0;
      c.pcOut = 1'b1;
      runCycle("pc readback", c);
      expPc = data + count;
      check("pc increment", expPc, lastBus);
    end

    $display("Result: PASSED");
    $finish;
  end

  initial begin
    #(limitNs);
    $display("timeout: the datapath sequences did not finish within %0d ns", limitNs);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule
